//--- src/seq_pkg.sv
// Shared sizes, operation and unit encodings, and operand decode helpers for the sequencer
package seq_pkg;

  // Instructions that may be in flight at once, one ID each
  localparam int unsigned NrVInsn = 8;
  // ALU, multiplier, load unit and store unit
  localparam int unsigned NrUnits = 4;
  localparam int unsigned NrVRegs = 32;
  // Instruction queue slots per unit unless the top level overrides them
  localparam int unsigned DefaultQueueDepth = 2;

  typedef logic [$clog2(NrVInsn)-1:0] vid_t;
  typedef logic [$clog2(NrVRegs)-1:0] vreg_t;
  // One bit per instruction ID, used for running sets and hazard rows
  typedef logic [NrVInsn-1:0] vid_vec_t;

  typedef enum logic [2:0] {
    OP_ADD,
    OP_SUB,
    OP_MUL,
    OP_MAC,
    OP_LOAD,
    OP_STORE
  } ara_op_e;

  // The order matches the done ports and the credit counters
  typedef enum logic [1:0] {
    UNIT_ALU,
    UNIT_MUL,
    UNIT_LOAD,
    UNIT_STORE
  } unit_e;

  // Every operation runs on exactly one functional unit
  function automatic unit_e op_unit(ara_op_e op);
    unit_e unit;
    unique case (op)
      OP_ADD, OP_SUB: unit = UNIT_ALU;
      OP_MUL, OP_MAC: unit = UNIT_MUL;
      OP_LOAD:        unit = UNIT_LOAD;
      OP_STORE:       unit = UNIT_STORE;
      default:        unit = UNIT_ALU;
    endcase
    return unit;
  endfunction

  // A load has no vector source, everything else reads vs1
  function automatic logic op_uses_vs1(ara_op_e op);
    return op inside {OP_ADD, OP_SUB, OP_MUL, OP_MAC, OP_STORE};
  endfunction

  function automatic logic op_uses_vs2(ara_op_e op);
    return op inside {OP_ADD, OP_SUB, OP_MUL, OP_MAC};
  endfunction

  // True when the operation writes vd, a store writes nothing
  function automatic logic op_uses_vd(ara_op_e op);
    return op inside {OP_ADD, OP_SUB, OP_MUL, OP_MAC, OP_LOAD};
  endfunction

endpackage

//--- src/vinsn_id_alloc.sv
// Tracks which instruction IDs run on which unit and hands out the lowest free ID
`timescale 1ns/1ps

module vinsn_id_alloc (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  logic                                      accept_i,
  input  seq_pkg::vid_t                             accept_id_i,
  input  seq_pkg::unit_e                            accept_unit_i,
  input  logic              [seq_pkg::NrUnits-1:0] done_valid_i,
  input  seq_pkg::vid_t     [seq_pkg::NrUnits-1:0] done_id_i,
  output seq_pkg::vid_vec_t                         running_o,
  output seq_pkg::vid_vec_t                         running_next_o,
  output seq_pkg::vid_t                             next_id_o,
  output logic                                      full_o,
  output logic                                      idle_o
);

  // Row u holds the IDs currently running on unit u
  seq_pkg::vid_vec_t [seq_pkg::NrUnits-1:0] unit_running_d, unit_running_q;

  always_comb begin
    unit_running_d = unit_running_q;
    // Completions first, then the new instruction
    // A done never names the ID being accepted, since that ID is free
    for (int u = 0; u < seq_pkg::NrUnits; u++) begin
      if (done_valid_i[u]) begin
        unit_running_d[u][done_id_i[u]] = 1'b0;
      end
    end
    if (accept_i) begin
      unit_running_d[accept_unit_i][accept_id_i] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      unit_running_q <= '0;
    end else begin
      unit_running_q <= unit_running_d;
    end
  end

  // An ID is busy as soon as any unit holds it
  always_comb begin
    running_o      = '0;
    running_next_o = '0;
    for (int u = 0; u < seq_pkg::NrUnits; u++) begin
      running_o      |= unit_running_q[u];
      running_next_o |= unit_running_d[u];
    end
  end

  // Priority encoder, scanning down so that the lowest clear bit wins
  always_comb begin
    next_id_o = '0;
    for (int i = seq_pkg::NrVInsn - 1; i >= 0; i--) begin
      if (!running_o[i]) begin
        next_id_o = seq_pkg::vid_t'(i);
      end
    end
  end

  assign full_o = &running_o;
  assign idle_o = ~|running_o;

  // A unit may only retire an instruction that was issued to it and is still open
  for (genvar u = 0; u < seq_pkg::NrUnits; u++) begin : gen_done_chk
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      done_valid_i[u] |-> unit_running_q[u][done_id_i[u]]);
  end

endmodule

//--- src/vreg_access_list.sv
// Per-register reader and writer lists that produce the RAW, WAR and WAW hazard vector
`timescale 1ns/1ps

module vreg_access_list (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              accept_i,
  input  seq_pkg::vid_t     accept_id_i,
  input  seq_pkg::ara_op_e  op_i,
  input  seq_pkg::vreg_t    vd_i,
  input  seq_pkg::vreg_t    vs1_i,
  input  seq_pkg::vreg_t    vs2_i,
  input  seq_pkg::vid_vec_t running_i,
  output seq_pkg::vid_vec_t hazard_o
);

  // Last instruction to read and to write each register
  seq_pkg::vid_t read_vid_d [seq_pkg::NrVRegs];
  seq_pkg::vid_t read_vid_q [seq_pkg::NrVRegs];
  seq_pkg::vid_t write_vid_d [seq_pkg::NrVRegs];
  seq_pkg::vid_t write_vid_q [seq_pkg::NrVRegs];
  logic [seq_pkg::NrVRegs-1:0] read_valid_d, read_valid_q;
  logic [seq_pkg::NrVRegs-1:0] write_valid_d, write_valid_q;

  // Entries whose owner is still in flight
  logic [seq_pkg::NrVRegs-1:0] read_live, write_live;

  logic use_vs1, use_vs2, use_vd;

  assign use_vs1 = seq_pkg::op_uses_vs1(op_i);
  assign use_vs2 = seq_pkg::op_uses_vs2(op_i);
  assign use_vd  = seq_pkg::op_uses_vd(op_i);

  for (genvar v = 0; v < seq_pkg::NrVRegs; v++) begin : gen_live
    assign read_live[v]  = read_valid_q[v] & running_i[read_vid_q[v]];
    assign write_live[v] = write_valid_q[v] & running_i[write_vid_q[v]];
  end

  //////////////////////////////
  // Hazard detection
  //////////////////////////////

  always_comb begin
    hazard_o = '0;
    // Read after write on each source that is used
    if (use_vs1 && write_live[vs1_i]) hazard_o[write_vid_q[vs1_i]] = 1'b1;
    if (use_vs2 && write_live[vs2_i]) hazard_o[write_vid_q[vs2_i]] = 1'b1;
    // Writing vd must wait for its last reader and its last writer
    if (use_vd) begin
      if (read_live[vd_i])  hazard_o[read_vid_q[vd_i]]  = 1'b1;
      if (write_live[vd_i]) hazard_o[write_vid_q[vd_i]] = 1'b1;
    end
  end

  //////////////////////////////
  // List update
  //////////////////////////////

  always_comb begin
    // Drop finished owners so a recycled ID does not revive a stale entry
    read_valid_d  = read_live;
    write_valid_d = write_live;
    read_vid_d    = read_vid_q;
    write_vid_d   = write_vid_q;
    if (accept_i) begin
      if (use_vd) begin
        write_vid_d[vd_i]   = accept_id_i;
        write_valid_d[vd_i] = 1'b1;
      end
      if (use_vs1) begin
        read_vid_d[vs1_i]   = accept_id_i;
        read_valid_d[vs1_i] = 1'b1;
      end
      if (use_vs2) begin
        read_vid_d[vs2_i]   = accept_id_i;
        read_valid_d[vs2_i] = 1'b1;
      end
      // The accumulator of a MAC is a read of vd as well
      if (op_i == seq_pkg::OP_MAC) begin
        read_vid_d[vd_i]   = accept_id_i;
        read_valid_d[vd_i] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      read_valid_q  <= '0;
      write_valid_q <= '0;
    end else begin
      read_valid_q  <= read_valid_d;
      write_valid_q <= write_valid_d;
    end
  end

  // IDs are only looked at behind their valid bit
  always_ff @(posedge clk_i) begin
    read_vid_q  <= read_vid_d;
    write_vid_q <= write_vid_d;
  end

endmodule

//--- src/unit_credit_counter.sv
// Counts the instructions queued at one functional unit and flags a free slot
`timescale 1ns/1ps

module unit_credit_counter #(
  parameter int unsigned Depth    = 2,
  parameter int unsigned CntWidth = 2
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic take_i,
  input  logic give_i,
  output logic credit_o
);

  // Instructions issued to the unit and not yet reported done
  logic [CntWidth-1:0] cnt_d, cnt_q;

  // An issue and a completion in the same cycle leave the count alone
  always_comb begin
    cnt_d = cnt_q;
    if (take_i && !give_i) begin
      cnt_d = cnt_q + 1'b1;
    end else if (give_i && !take_i) begin
      cnt_d = cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // Credit is left while the queue has a slot
  assign credit_o = (cnt_q < Depth);

  // The issue side must never spend a credit it does not have
  assert property (@(posedge clk_i) disable iff (!rst_ni) cnt_q <= Depth);

  // The unit must never return more credits than it was given
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (give_i && !take_i) |-> (cnt_q != '0));

endmodule

//--- src/hazard_table.sv
// Global hazard table exported to the lanes, one dependency row per instruction ID
`timescale 1ns/1ps

module hazard_table (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  logic                                      accept_i,
  input  seq_pkg::vid_t                             accept_id_i,
  input  seq_pkg::vid_vec_t                         hazard_i,
  input  seq_pkg::vid_vec_t                         running_i,
  output seq_pkg::vid_vec_t [seq_pkg::NrVInsn-1:0] table_o
);

  // Row r lists the IDs that instruction r still waits on
  seq_pkg::vid_vec_t [seq_pkg::NrVInsn-1:0] table_d, table_q;

  always_comb begin
    table_d = table_q;
    // The new instruction takes over the row of its ID
    if (accept_i) begin
      table_d[accept_id_i] = hazard_i;
    end
    // running_i already excludes this cycle's completions,
    // so finished IDs vanish from every row at the completion edge
    for (int r = 0; r < seq_pkg::NrVInsn; r++) begin
      table_d[r] &= running_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      table_q <= '0;
    end else begin
      table_q <= table_d;
    end
  end

  assign table_o = table_q;

endmodule

//--- src/issue_ctrl.sv
// Decides acceptance of the upstream request and registers the issued instruction
`timescale 1ns/1ps

module issue_ctrl (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  // Upstream request
  input  logic                             req_valid_i,
  input  seq_pkg::ara_op_e                 req_op_i,
  input  seq_pkg::vreg_t                   req_vd_i,
  input  seq_pkg::vreg_t                   req_vs1_i,
  input  seq_pkg::vreg_t                   req_vs2_i,
  output logic                             req_ready_o,
  // State from the allocator, the credit counters and the access lists
  input  seq_pkg::vid_t                    next_id_i,
  input  logic                             id_full_i,
  input  logic       [seq_pkg::NrUnits-1:0] unit_credit_i,
  input  seq_pkg::vid_vec_t                hazard_i,
  output logic                             accept_o,
  // Issue towards the functional units
  output logic                             issue_valid_o,
  output seq_pkg::vid_t                    issue_id_o,
  output seq_pkg::unit_e                   issue_unit_o,
  output seq_pkg::ara_op_e                 issue_op_o,
  output seq_pkg::vreg_t                   issue_vd_o,
  output seq_pkg::vreg_t                   issue_vs1_o,
  output seq_pkg::vreg_t                   issue_vs2_o,
  output seq_pkg::vid_vec_t                issue_hazard_o
);

  seq_pkg::unit_e req_unit;

  //////////////////////////////
  // Accept decision
  //////////////////////////////

  assign req_unit = seq_pkg::op_unit(req_op_i);

  // Ready looks at registered state only and never at valid
  // The target unit needs a credit and a free ID must exist
  assign req_ready_o = unit_credit_i[req_unit] & ~id_full_i;
  assign accept_o    = req_valid_i & req_ready_o;

  //////////////////////////////
  // Issue register
  //////////////////////////////

  // One-cycle pulse per accepted instruction
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issue_valid_o <= 1'b0;
    end else begin
      issue_valid_o <= accept_o;
    end
  end

  // Fields are only meaningful while issue_valid_o is high
  always_ff @(posedge clk_i) begin
    if (accept_o) begin
      issue_id_o     <= next_id_i;
      issue_unit_o   <= req_unit;
      issue_op_o     <= req_op_i;
      issue_vd_o     <= req_vd_i;
      issue_vs1_o    <= req_vs1_i;
      issue_vs2_o    <= req_vs2_i;
      issue_hazard_o <= hazard_i;
    end
  end

  // A unit runs out of credit only at the edge that issues an instruction to it
  for (genvar u = 0; u < seq_pkg::NrUnits; u++) begin : gen_credit_chk
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      $fell(unit_credit_i[u]) |-> (issue_valid_o && issue_unit_o == seq_pkg::unit_e'(u)));
  end

endmodule

//--- src/vinsn_sequencer.sv
// Vector instruction sequencer top level, accepts requests and issues them to four units
`timescale 1ns/1ps

module vinsn_sequencer #(
  // Queue slots of ALU, multiplier, load unit and store unit
  parameter int unsigned QueueDepth [seq_pkg::NrUnits] = '{default: seq_pkg::DefaultQueueDepth},
  // Wide enough to hold the deepest queue, written out for the four units
  parameter int unsigned CntWidth = $clog2(
    (((QueueDepth[0] > QueueDepth[1]) ? QueueDepth[0] : QueueDepth[1]) >
     ((QueueDepth[2] > QueueDepth[3]) ? QueueDepth[2] : QueueDepth[3]))
      ? ((QueueDepth[0] > QueueDepth[1]) ? QueueDepth[0] : QueueDepth[1]) + 1
      : ((QueueDepth[2] > QueueDepth[3]) ? QueueDepth[2] : QueueDepth[3]) + 1)
) (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  logic                                      req_valid_i,
  input  seq_pkg::ara_op_e                          req_op_i,
  input  seq_pkg::vreg_t                            req_vd_i,
  input  seq_pkg::vreg_t                            req_vs1_i,
  input  seq_pkg::vreg_t                            req_vs2_i,
  output logic                                      req_ready_o,
  output logic                                      issue_valid_o,
  output seq_pkg::vid_t                             issue_id_o,
  output seq_pkg::unit_e                            issue_unit_o,
  output seq_pkg::ara_op_e                          issue_op_o,
  output seq_pkg::vreg_t                            issue_vd_o,
  output seq_pkg::vreg_t                            issue_vs1_o,
  output seq_pkg::vreg_t                            issue_vs2_o,
  output seq_pkg::vid_vec_t                         issue_hazard_o,
  output seq_pkg::vid_vec_t [seq_pkg::NrVInsn-1:0] hazard_table_o,
  output logic                                      idle_o,
  input  logic              [seq_pkg::NrUnits-1:0] done_valid_i,
  input  seq_pkg::vid_t     [seq_pkg::NrUnits-1:0] done_id_i
);

  logic                        accept;
  seq_pkg::unit_e              req_unit;
  seq_pkg::vid_t               next_id;
  logic                        id_full;
  seq_pkg::vid_vec_t           running, running_next, hazard;
  logic [seq_pkg::NrUnits-1:0] unit_credit, take;

  assign req_unit = seq_pkg::op_unit(req_op_i);

  issue_ctrl i_issue_ctrl (
    .clk_i         (clk_i),          .rst_ni        (rst_ni),
    .req_valid_i   (req_valid_i),    .req_op_i      (req_op_i),
    .req_vd_i      (req_vd_i),       .req_vs1_i     (req_vs1_i),
    .req_vs2_i     (req_vs2_i),      .req_ready_o   (req_ready_o),
    .next_id_i     (next_id),        .id_full_i     (id_full),
    .unit_credit_i (unit_credit),    .hazard_i      (hazard),
    .accept_o      (accept),         .issue_valid_o (issue_valid_o),
    .issue_id_o    (issue_id_o),     .issue_unit_o  (issue_unit_o),
    .issue_op_o    (issue_op_o),     .issue_vd_o    (issue_vd_o),
    .issue_vs1_o   (issue_vs1_o),    .issue_vs2_o   (issue_vs2_o),
    .issue_hazard_o(issue_hazard_o)
  );

  vinsn_id_alloc i_id_alloc (
    .clk_i         (clk_i),          .rst_ni        (rst_ni),
    .accept_i      (accept),         .accept_id_i   (next_id),
    .accept_unit_i (req_unit),       .done_valid_i  (done_valid_i),
    .done_id_i     (done_id_i),      .running_o     (running),
    .running_next_o(running_next),   .next_id_o     (next_id),
    .full_o        (id_full),        .idle_o        (idle_o)
  );

  // Hazards are seen against the state before the accepting edge
  vreg_access_list i_access_list (
    .clk_i      (clk_i),      .rst_ni     (rst_ni),
    .accept_i   (accept),     .accept_id_i(next_id),
    .op_i       (req_op_i),   .vd_i       (req_vd_i),
    .vs1_i      (req_vs1_i),  .vs2_i      (req_vs2_i),
    .running_i  (running),    .hazard_o   (hazard)
  );

  // The table is masked with the running set after this cycle's completions
  hazard_table i_hazard_table (
    .clk_i      (clk_i),         .rst_ni     (rst_ni),
    .accept_i   (accept),        .accept_id_i(next_id),
    .hazard_i   (hazard),        .running_i  (running_next),
    .table_o    (hazard_table_o)
  );

  // One credit counter per unit, a done report returns the credit
  for (genvar u = 0; u < seq_pkg::NrUnits; u++) begin : gen_credit
    assign take[u] = accept & (req_unit == seq_pkg::unit_e'(u));

    unit_credit_counter #(
      .Depth   (QueueDepth[u]),
      .CntWidth(CntWidth)
    ) i_credit (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .take_i  (take[u]),
      .give_i  (done_valid_i[u]),
      .credit_o(unit_credit[u])
    );
  end

endmodule

//--- bench/seq_model.svh
// Reference model of IDs, credits, access lists and hazard rows, included into the testbench module
`ifndef SEQ_MODEL_SVH
`define SEQ_MODEL_SVH

// IDs running per unit and credits spent per unit
seq_pkg::vid_vec_t m_unit_run [seq_pkg::NrUnits];
int unsigned       m_used [seq_pkg::NrUnits];
// Last reader and last writer of every register, each behind a valid bit
seq_pkg::vid_t               m_rd_id [seq_pkg::NrVRegs];
seq_pkg::vid_t               m_wr_id [seq_pkg::NrVRegs];
logic [seq_pkg::NrVRegs-1:0] m_rd_ok;
logic [seq_pkg::NrVRegs-1:0] m_wr_ok;
seq_pkg::vid_vec_t [seq_pkg::NrVInsn-1:0] m_table;

// ADD and SUB on the ALU, MUL and MAC on the multiplier, memory ops on their own units
function automatic seq_pkg::unit_e target_unit(input seq_pkg::ara_op_e op);
  case (op)
    seq_pkg::OP_ADD, seq_pkg::OP_SUB: return seq_pkg::UNIT_ALU;
    seq_pkg::OP_MUL, seq_pkg::OP_MAC: return seq_pkg::UNIT_MUL;
    seq_pkg::OP_LOAD:                 return seq_pkg::UNIT_LOAD;
    default:                          return seq_pkg::UNIT_STORE;
  endcase
endfunction

// Only a load has no vector source
function automatic logic reads_vs1(input seq_pkg::ara_op_e op);
  return op != seq_pkg::OP_LOAD;
endfunction

// Memory ops carry a single vector operand at most
function automatic logic reads_vs2(input seq_pkg::ara_op_e op);
  return op != seq_pkg::OP_LOAD && op != seq_pkg::OP_STORE;
endfunction

function automatic logic writes_vd(input seq_pkg::ara_op_e op);
  return op != seq_pkg::OP_STORE;
endfunction

function automatic seq_pkg::vid_vec_t running_set();
  seq_pkg::vid_vec_t run;
  run = '0;
  for (int u = 0; u < seq_pkg::NrUnits; u++) begin
    run |= m_unit_run[u];
  end
  return run;
endfunction

function automatic seq_pkg::vid_t lowest_free_id();
  seq_pkg::vid_vec_t run;
  run = running_set();
  for (int i = 0; i < seq_pkg::NrVInsn; i++) begin
    if (!run[i]) return seq_pkg::vid_t'(i);
  end
  return '0;
endfunction

// A request goes through when its unit has a free slot and some ID is free
function automatic logic may_accept(input seq_pkg::ara_op_e op);
  return (m_used[target_unit(op)] < seq_pkg::DefaultQueueDepth) && (running_set() != '1);
endfunction

// RAW on used sources, WAR and WAW on a written vd, counted only for running owners
function automatic seq_pkg::vid_vec_t expected_hazard(
  input seq_pkg::ara_op_e op,
  input seq_pkg::vreg_t   vd,
  input seq_pkg::vreg_t   vs1,
  input seq_pkg::vreg_t   vs2
);
  seq_pkg::vid_vec_t run;
  seq_pkg::vid_vec_t haz;
  run = running_set();
  haz = '0;
  if (reads_vs1(op) && m_wr_ok[vs1] && run[m_wr_id[vs1]]) haz[m_wr_id[vs1]] = 1'b1;
  if (reads_vs2(op) && m_wr_ok[vs2] && run[m_wr_id[vs2]]) haz[m_wr_id[vs2]] = 1'b1;
  if (writes_vd(op)) begin
    if (m_rd_ok[vd] && run[m_rd_id[vd]]) haz[m_rd_id[vd]] = 1'b1;
    if (m_wr_ok[vd] && run[m_wr_id[vd]]) haz[m_wr_id[vd]] = 1'b1;
  end
  return haz;
endfunction

task automatic reset_model();
  for (int u = 0; u < seq_pkg::NrUnits; u++) begin
    m_unit_run[u] = '0;
    m_used[u]     = 0;
  end
  for (int v = 0; v < seq_pkg::NrVRegs; v++) begin
    m_rd_id[v] = '0;
    m_wr_id[v] = '0;
  end
  m_rd_ok = '0;
  m_wr_ok = '0;
  m_table = '0;
endtask

// One clock edge of the sequencer, completions first and then the accepted instruction
task automatic update_model(
  input logic                                  acc,
  input seq_pkg::vid_t                         id,
  input seq_pkg::ara_op_e                      op,
  input seq_pkg::vreg_t                        vd,
  input seq_pkg::vreg_t                        vs1,
  input seq_pkg::vreg_t                        vs2,
  input seq_pkg::vid_vec_t                     haz,
  input logic          [seq_pkg::NrUnits-1:0] dv,
  input seq_pkg::vid_t [seq_pkg::NrUnits-1:0] did
);
  seq_pkg::vid_vec_t run;
  // A finished ID returns its credit and leaves no entry that a reused ID could revive
  for (int u = 0; u < seq_pkg::NrUnits; u++) begin
    if (dv[u]) begin
      m_unit_run[u][did[u]] = 1'b0;
      m_used[u]--;
      for (int v = 0; v < seq_pkg::NrVRegs; v++) begin
        if (m_rd_id[v] == did[u]) m_rd_ok[v] = 1'b0;
        if (m_wr_id[v] == did[u]) m_wr_ok[v] = 1'b0;
      end
    end
  end
  if (acc) begin
    m_unit_run[target_unit(op)][id] = 1'b1;
    m_used[target_unit(op)]++;
    if (writes_vd(op)) begin
      m_wr_id[vd] = id;
      m_wr_ok[vd] = 1'b1;
    end
    if (reads_vs1(op)) begin
      m_rd_id[vs1] = id;
      m_rd_ok[vs1] = 1'b1;
    end
    if (reads_vs2(op)) begin
      m_rd_id[vs2] = id;
      m_rd_ok[vs2] = 1'b1;
    end
    // The MAC accumulator counts as a read of vd
    if (op == seq_pkg::OP_MAC) begin
      m_rd_id[vd] = id;
      m_rd_ok[vd] = 1'b1;
    end
    m_table[id] = haz;
  end
  // Rows keep only IDs still running after this edge
  run = running_set();
  for (int r = 0; r < seq_pkg::NrVInsn; r++) begin
    m_table[r] &= run;
  end
endtask

`endif

//--- bench/tb_vinsn_sequencer.sv
// Random-stimulus testbench for the sequencer, run as top module against the included model
`timescale 1ns/1ps

module tb_vinsn_sequencer;

  localparam int ResetCycles = 16;
  localparam int BurstCycles = 4;
  localparam int RunCycles   = 3000;
  localparam int DrainMax    = 200;
  // Reset, probes, burst, run and drain take about 3240 cycles, the rest is margin
  localparam int TimeoutCycles = 4000;

  logic                                     clk_i;
  logic                                     rst_ni;
  logic                                     req_valid_i;
  seq_pkg::ara_op_e                         req_op_i;
  seq_pkg::vreg_t                           req_vd_i;
  seq_pkg::vreg_t                           req_vs1_i;
  seq_pkg::vreg_t                           req_vs2_i;
  logic                                     req_ready_o;
  logic                                     issue_valid_o;
  seq_pkg::vid_t                            issue_id_o;
  seq_pkg::unit_e                           issue_unit_o;
  seq_pkg::ara_op_e                         issue_op_o;
  seq_pkg::vreg_t                           issue_vd_o;
  seq_pkg::vreg_t                           issue_vs1_o;
  seq_pkg::vreg_t                           issue_vs2_o;
  seq_pkg::vid_vec_t                        issue_hazard_o;
  seq_pkg::vid_vec_t [seq_pkg::NrVInsn-1:0] hazard_table_o;
  logic                                     idle_o;
  logic          [seq_pkg::NrUnits-1:0]     done_valid_i;
  seq_pkg::vid_t [seq_pkg::NrUnits-1:0]     done_id_i;

  // Issue expected in the cycle after the edge the model just applied
  logic                      exp_valid;
  seq_pkg::vid_t             exp_id;
  seq_pkg::unit_e            exp_unit;
  seq_pkg::ara_op_e          exp_op;
  seq_pkg::vreg_t [2:0]      exp_regs;
  seq_pkg::vid_vec_t         exp_haz;

  int     ready_errs;
  int     issue_errs;
  int     table_errs;
  int     idle_errs;
  int     cycle_cnt = 0;
  int     drained;
  integer seed;

  `include "seq_model.svh"

  vinsn_sequencer dut0 (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_valid_i   (req_valid_i),
    .req_op_i      (req_op_i),
    .req_vd_i      (req_vd_i),
    .req_vs1_i     (req_vs1_i),
    .req_vs2_i     (req_vs2_i),
    .req_ready_o   (req_ready_o),
    .issue_valid_o (issue_valid_o),
    .issue_id_o    (issue_id_o),
    .issue_unit_o  (issue_unit_o),
    .issue_op_o    (issue_op_o),
    .issue_vd_o    (issue_vd_o),
    .issue_vs1_o   (issue_vs1_o),
    .issue_vs2_o   (issue_vs2_o),
    .issue_hazard_o(issue_hazard_o),
    .hazard_table_o(hazard_table_o),
    .idle_o        (idle_o),
    .done_valid_i  (done_valid_i),
    .done_id_i     (done_id_i)
  );

  always #10 clk_i = ~clk_i;

  // Hard stop in case the DUT never drains or a wait hangs
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TimeoutCycles) begin
      $display("Timeout after %0d cycles, the run did not complete", cycle_cnt);
      $display("Verification failed");
      $finish;
    end
  end

  //////////////////////////////
  // Compare tasks
  //////////////////////////////

  task automatic check_ready(input logic got, input logic exp);
    if (got !== exp) begin
      ready_errs++;
      $display("FAILED %0t: req_ready_o is %b, expected %b for op %s",
               $time, got, exp, req_op_i.name());
    end
  endtask

  task automatic check_issue(
    input logic                 got_valid,
    input logic                 exp_valid,
    input seq_pkg::vid_t        got_id,
    input seq_pkg::vid_t        exp_id,
    input seq_pkg::unit_e       got_unit,
    input seq_pkg::unit_e       exp_unit,
    input seq_pkg::ara_op_e     got_op,
    input seq_pkg::ara_op_e     exp_op,
    input seq_pkg::vreg_t [2:0] got_regs,
    input seq_pkg::vreg_t [2:0] exp_regs,
    input seq_pkg::vid_vec_t    got_haz,
    input seq_pkg::vid_vec_t    exp_haz
  );
    if (got_valid !== exp_valid) begin
      issue_errs++;
      $display("FAILED %0t: issue_valid_o is %b, expected %b", $time, got_valid, exp_valid);
    end else if (exp_valid && (got_id !== exp_id || got_unit !== exp_unit ||
                 got_op !== exp_op || got_regs !== exp_regs || got_haz !== exp_haz)) begin
      issue_errs++;
      $display("FAILED %0t: issue id %0d unit %s op %s regs %h hazard %b", $time,
               got_id, got_unit.name(), got_op.name(), got_regs, got_haz);
      $display("  expected id %0d unit %s op %s regs %h hazard %b",
               exp_id, exp_unit.name(), exp_op.name(), exp_regs, exp_haz);
    end
  endtask

  task automatic check_table(
    input seq_pkg::vid_vec_t [seq_pkg::NrVInsn-1:0] got,
    input seq_pkg::vid_vec_t [seq_pkg::NrVInsn-1:0] exp
  );
    for (int r = 0; r < seq_pkg::NrVInsn; r++) begin
      if (got[r] !== exp[r]) begin
        table_errs++;
        $display("FAILED %0t: hazard table row %0d is %b, expected %b", $time, r, got[r], exp[r]);
      end
    end
  endtask

  task automatic check_idle(input logic got, input logic exp);
    if (got !== exp) begin
      idle_errs++;
      $display("FAILED %0t: idle_o is %b, expected %b", $time, got, exp);
    end
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  // Picks the position-th set bit of an ID set
  function automatic seq_pkg::vid_t nth_set_id(input seq_pkg::vid_vec_t set, input int position);
    int seen;
    seen = 0;
    for (int i = 0; i < seq_pkg::NrVInsn; i++) begin
      if (set[i]) begin
        if (seen == position) return seq_pkg::vid_t'(i);
        seen++;
      end
    end
    return '0;
  endfunction

  // Mode 0 holds valid low on op, mode 1 sends a random request, mode 2 sends op with valid high
  task automatic step(input int mode, input seq_pkg::ara_op_e op, input bit gen_done);
    logic              acc;
    seq_pkg::vid_t     id;
    seq_pkg::vid_vec_t haz;
    int                n;
    @(posedge clk_i);
    // The inputs seen here are those the DUT samples at this same edge
    acc = req_valid_i && may_accept(req_op_i);
    id  = lowest_free_id();
    haz = expected_hazard(req_op_i, req_vd_i, req_vs1_i, req_vs2_i);
    update_model(acc, id, req_op_i, req_vd_i, req_vs1_i, req_vs2_i, haz,
                 done_valid_i, done_id_i);
    exp_valid = acc;
    exp_id    = id;
    exp_unit  = target_unit(req_op_i);
    exp_op    = req_op_i;
    exp_regs  = {req_vd_i, req_vs1_i, req_vs2_i};
    exp_haz   = haz;
    // Valid is high three times in four in random mode
    if (mode == 1) begin
      req_valid_i <= ({$random(seed)} % 4) != 0;
      req_op_i    <= seq_pkg::ara_op_e'({$random(seed)} % 6);
    end else begin
      req_valid_i <= (mode == 2);
      req_op_i    <= op;
    end
    req_vd_i  <= seq_pkg::vreg_t'($random(seed));
    req_vs1_i <= seq_pkg::vreg_t'($random(seed));
    req_vs2_i <= seq_pkg::vreg_t'($random(seed));
    // Each unit retires one of its open IDs with probability one third
    for (int u = 0; u < seq_pkg::NrUnits; u++) begin
      n = $countones(m_unit_run[u]);
      if (gen_done && n != 0 && ({$random(seed)} % 3) == 0) begin
        done_valid_i[u] <= 1'b1;
        done_id_i[u]    <= nth_set_id(m_unit_run[u], {$random(seed)} % n);
      end else begin
        done_valid_i[u] <= 1'b0;
      end
    end
    @(negedge clk_i);
    check_ready(req_ready_o, may_accept(req_op_i));
    check_issue(issue_valid_o, exp_valid, issue_id_o, exp_id, issue_unit_o, exp_unit,
                issue_op_o, exp_op, {issue_vd_o, issue_vs1_o, issue_vs2_o}, exp_regs,
                issue_hazard_o, exp_haz);
    check_table(hazard_table_o, m_table);
    check_idle(idle_o, running_set() == '0);
  endtask

  initial begin
    seed         = 32'h93e3;
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    req_valid_i  = 1'b0;
    req_op_i     = seq_pkg::OP_ADD;
    req_vd_i     = '0;
    req_vs1_i    = '0;
    req_vs2_i    = '0;
    done_valid_i = '0;
    done_id_i    = '0;
    exp_valid    = 1'b0;
    ready_errs   = 0;
    issue_errs   = 0;
    table_errs   = 0;
    idle_errs    = 0;
    reset_model();
    repeat (ResetCycles) @(posedge clk_i);
    rst_ni <= 1'b1;

    // Out of reset every op finds a credit and a free ID
    for (int k = 0; k < 6; k++) begin
      step(0, seq_pkg::ara_op_e'(k), 1'b0);
      check_ready(req_ready_o, 1'b1);
    end
    check_idle(idle_o, 1'b1);
    check_table(hazard_table_o, '0);

    // Multiplier burst with no completions runs out of credits
    repeat (BurstCycles) step(2, seq_pkg::OP_MUL, 1'b0);
    check_ready(req_ready_o, 1'b0);

    repeat (RunCycles) step(1, seq_pkg::OP_ADD, 1'b1);

    // Stop requests and let the units retire what is left
    drained = 0;
    do begin
      step(0, seq_pkg::OP_ADD, 1'b1);
      drained++;
    end while (running_set() != '0 && drained < DrainMax);
    if (running_set() != '0) begin
      idle_errs++;
      $display("Instructions still in flight after %0d drain cycles", drained);
    end
    check_idle(idle_o, 1'b1);

    $display("Errors: ready %0d, issue %0d, table %0d, idle %0d",
             ready_errs, issue_errs, table_errs, idle_errs);
    if (ready_errs + issue_errs + table_errs + idle_errs == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- project.f
+incdir+bench
src/seq_pkg.sv
src/vinsn_id_alloc.sv
src/vreg_access_list.sv
src/unit_credit_counter.sv
src/hazard_table.sv
src/issue_ctrl.sv
src/vinsn_sequencer.sv
bench/tb_vinsn_sequencer.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it, the exit status follows the result

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
  -f project.f --top-module tb_vinsn_sequencer -o tb_vinsn_sequencer &&
./obj_dir/tb_vinsn_sequencer | tee /dev/stderr | grep -q "Verification passed" &&
echo "Simulation run succeeded" ||
{ echo "Simulation run failed"; exit 1; }
